//--- mac_rx_pkg.sv
package mac_rx_pkg;

  // gmii framing bytes
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // classification on the low ethertype byte
  localparam int         TYPE_BYTE_INDEX = 13;
  localparam logic [7:0] TTE_TYPE_LO     = 8'h92;

  // remainder left by a good frame incl. fcs
  localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

  localparam int MIN_FRAME = 64;  // bytes incl. fcs
  localparam int FCS_BYTES = 4;
  localparam int LEN_W     = 13;  // byte count width

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_RECEIVE,
    ST_COPY,
    ST_DESC,
    ST_REPORT
  } rx_state_e;

  typedef enum logic {
    CLASS_BE,
    CLASS_TTE
  } frame_class_e;

endpackage

//--- mac_desc_pkg.sv
package mac_desc_pkg;

  // pushed into the descriptor fifo after the frame bytes
  typedef struct packed {
    logic                         giant;
    logic                         runt;
    logic                         crc_err;
    logic [mac_rx_pkg::LEN_W-1:0] len;  // stored bytes, fcs stripped
  } rx_desc_t;

  // management report, one per frame
  typedef struct packed {
    logic        drop;     // no room in the chosen queue
    logic        giant;
    logic        runt;
    logic        crc_err;
    logic [2:0]  rsvd;     // always zero
    logic        tte;
    logic [11:0] len;      // zero when dropped
  } mgnt_report_t;

endpackage

//--- mac_rx_byte_cnt.sv
`timescale 1ns/100ps

module mac_rx_byte_cnt #(
  parameter int MAX_FRAME = 1518
) (
  input  logic                         rx_clk,
  input  logic                         rstn_mac,
  input  logic                         clr,
  input  logic                         inc,
  output logic [mac_rx_pkg::LEN_W-1:0] cnt,
  output logic                         at_limit
);
  import mac_rx_pkg::*;

  localparam logic [LEN_W-1:0] LIMIT = LEN_W'(MAX_FRAME);

  assign at_limit = (cnt == LIMIT);

  // write address on receive, read address on copy
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      cnt <= '0;
    end else if (clr) begin
      cnt <= '0;
    end else if (inc && !at_limit) begin  // holds at the limit
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- mac_rx_crc32.sv
`timescale 1ns/100ps

module mac_rx_crc32 (
  input  logic       rx_clk,
  input  logic       rstn_mac,
  input  logic       init,
  input  logic       en,
  input  logic [7:0] din,
  output logic       crc_ok
);
  import mac_rx_pkg::*;

  localparam logic [31:0] POLY = 32'h04C11DB7;

  logic [31:0] crc_q;

  // one byte through the ieee 802.3 lfsr
  // bits enter lsb first, the order they arrive on the wire
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[31] ^ d[i];
      c  = {c[30:0], 1'b0};
      if (fb)
        c = c ^ POLY;
    end
    return c;
  endfunction

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      crc_q <= '1;
    end else if (init) begin
      crc_q <= '1;                    // preset for a new frame
    end else if (en) begin
      crc_q <= crc_step(crc_q, din);
    end
  end

  // fcs included, so a clean frame leaves the fixed remainder
  assign crc_ok = (crc_q == CRC_RESIDUE);

endmodule

//--- mac_rx_frame_buf.sv
`timescale 1ns/100ps

module mac_rx_frame_buf #(
  parameter int MAX_FRAME = 1518
) (
  input  logic                         rx_clk,
  input  logic                         wr,
  input  logic [$clog2(MAX_FRAME)-1:0] waddr,
  input  logic [7:0]                   wdata,
  input  logic                         rd,
  input  logic [$clog2(MAX_FRAME)-1:0] raddr,
  output logic [7:0]                   rdata
);

  // one frame, written on receive and read back on copy
  logic [7:0] mem [MAX_FRAME];

  always_ff @(posedge rx_clk) begin
    if (wr)
      mem[waddr] <= wdata;
  end

  // registered read port
  always_ff @(posedge rx_clk) begin
    if (rd)
      rdata <= mem[raddr];
  end

endmodule

//--- mac_rx_queue.sv
`timescale 1ns/100ps

module mac_rx_queue #(
  parameter int DATA_DEPTH = 4096,
  parameter int DESC_DEPTH = 8,
  parameter int MAX_FRAME  = 1518
) (
  input  logic                   rx_clk,
  input  logic                   rstn_mac,
  input  logic                   data_wr,
  input  logic [7:0]             data_in,
  input  logic                   data_rd,
  output logic [7:0]             data_dout,
  input  logic                   desc_wr,
  input  mac_desc_pkg::rx_desc_t desc_in,
  input  logic                   desc_rd,
  output mac_desc_pkg::rx_desc_t desc_dout,
  output logic                   desc_empty,
  output logic                   room
);
  import mac_desc_pkg::*;

  // depths are powers of two, pointers wrap on their own
  localparam int DAW = $clog2(DATA_DEPTH);
  localparam int QAW = $clog2(DESC_DEPTH);
  localparam logic [DAW:0] DATA_FULL = (DAW+1)'(DATA_DEPTH);
  localparam logic [DAW:0] DATA_ROOM = (DAW+1)'(DATA_DEPTH - MAX_FRAME);
  localparam logic [QAW:0] DESC_FULL = (QAW+1)'(DESC_DEPTH);

  logic [7:0]     data_mem [DATA_DEPTH];
  logic [DAW-1:0] data_wptr;
  logic [DAW-1:0] data_rptr;
  logic [DAW:0]   data_cnt;
  logic           data_push;
  logic           data_pop;

  rx_desc_t       desc_mem [DESC_DEPTH];
  logic [QAW-1:0] desc_wptr;
  logic [QAW-1:0] desc_rptr;
  logic [QAW:0]   desc_cnt;
  logic           desc_push;
  logic           desc_pop;

  assign data_push = data_wr && (data_cnt != DATA_FULL);
  assign data_pop  = data_rd && (data_cnt != '0);   // empty read ignored
  assign desc_push = desc_wr && (desc_cnt != DESC_FULL);
  assign desc_pop  = desc_rd && (desc_cnt != '0);

  // ==========================================================
  // byte fifo
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      data_wptr <= '0;
      data_rptr <= '0;
      data_cnt  <= '0;
    end else begin
      if (data_push)
        data_wptr <= data_wptr + 1'b1;
      if (data_pop)
        data_rptr <= data_rptr + 1'b1;
      data_cnt <= data_cnt + (DAW+1)'(data_push) - (DAW+1)'(data_pop);
    end
  end

  always_ff @(posedge rx_clk) begin
    if (data_push)
      data_mem[data_wptr] <= data_in;
    if (data_pop)
      data_dout <= data_mem[data_rptr];
  end

  // ==========================================================
  // descriptor fifo
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      desc_wptr <= '0;
      desc_rptr <= '0;
      desc_cnt  <= '0;
    end else begin
      if (desc_push)
        desc_wptr <= desc_wptr + 1'b1;
      if (desc_pop)
        desc_rptr <= desc_rptr + 1'b1;
      desc_cnt <= desc_cnt + (QAW+1)'(desc_push) - (QAW+1)'(desc_pop);
    end
  end

  always_ff @(posedge rx_clk) begin
    if (desc_push)
      desc_mem[desc_wptr] <= desc_in;
    if (desc_pop)
      desc_dout <= desc_mem[desc_rptr];
  end

  assign desc_empty = (desc_cnt == '0);

  // space for a worst case frame and its descriptor
  assign room = (data_cnt <= DATA_ROOM) && (desc_cnt != DESC_FULL);

endmodule

//--- mac_rx_frame_fsm.sv
`timescale 1ns/100ps

module mac_rx_frame_fsm #(
  parameter int MAX_FRAME = 1518
) (
  input  logic                         rx_clk,
  input  logic                         rstn_mac,
  input  logic                         dv,
  input  logic [7:0]                   din,
  input  logic [mac_rx_pkg::LEN_W-1:0] cnt,
  input  logic                         at_limit,
  input  logic                         crc_ok,
  input  logic                         be_room,
  input  logic                         tte_room,
  input  logic                         mgnt_resp,
  input  logic [7:0]                   buf_dout,
  output logic                         byte_inc,
  output logic                         byte_clr,
  output logic                         buf_wr,
  output logic                         buf_rd,
  output logic                         be_data_wr,
  output logic                         tte_data_wr,
  output logic [7:0]                   data_out,
  output logic                         be_desc_wr,
  output logic                         tte_desc_wr,
  output mac_desc_pkg::rx_desc_t       desc,
  output logic                         mgnt_valid,
  output mac_desc_pkg::mgnt_report_t   mgnt_report
);
  import mac_rx_pkg::*;
  import mac_desc_pkg::*;

  rx_state_e        state;
  rx_state_e        state_nxt;
  frame_class_e     cls_q;
  logic             dv_d;
  logic             rd_d;
  logic             sof;
  logic             sfd;
  logic             start;
  logic             eof;
  logic             room_sel;
  logic [LEN_W-1:0] len_nxt;

  // report len is 12 bits
  if (MAX_FRAME - FCS_BYTES > 4095) begin : g_len_chk
    $error("MAX_FRAME exceeds the report length field");
  end

  assign sof      = dv && !dv_d;
  assign sfd      = dv && (din == SFD_BYTE);
  assign start    = ((state == ST_IDLE) && sof && sfd) || ((state == ST_PREAMBLE) && sfd);
  assign eof      = (state == ST_RECEIVE) && (!dv || at_limit);
  assign room_sel = (cls_q == CLASS_TTE) ? tte_room : be_room;
  assign len_nxt  = (cnt > LEN_W'(FCS_BYTES)) ? cnt - LEN_W'(FCS_BYTES) : '0;

  // ==========================================================
  // state machine
  // ==========================================================
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (sof)                                 // mid-frame dv is ignored
          state_nxt = sfd ? ST_RECEIVE : ST_PREAMBLE;
      end
      ST_PREAMBLE: begin
        if (sfd)
          state_nxt = ST_RECEIVE;
        else if (!dv || (din != PREAMBLE_BYTE))  // line dropped or bad preamble
          state_nxt = ST_IDLE;
      end
      ST_RECEIVE: begin
        if (eof)
          state_nxt = room_sel ? ST_COPY : ST_REPORT;
      end
      ST_COPY: begin
        if (cnt + 1'b1 >= desc.len)              // last read issued
          state_nxt = ST_DESC;
      end
      ST_DESC:
        state_nxt = ST_REPORT;
      ST_REPORT: begin
        if (mgnt_resp)
          state_nxt = ST_IDLE;
      end
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state <= ST_IDLE;
      dv_d  <= 1'b0;
      rd_d  <= 1'b0;
      cls_q <= CLASS_BE;
    end else begin
      state <= state_nxt;
      dv_d  <= dv;
      rd_d  <= buf_rd;                           // matches buffer read latency
      if (start)
        cls_q <= CLASS_BE;
      else if (buf_wr && (cnt == LEN_W'(TYPE_BYTE_INDEX)))
        cls_q <= (din == TTE_TYPE_LO) ? CLASS_TTE : CLASS_BE;
    end
  end

  // ==========================================================
  // counter, buffer and queue strobes
  // ==========================================================
  assign byte_clr    = start || eof;             // eof rewinds for the copy
  assign buf_wr      = (state == ST_RECEIVE) && dv && !at_limit;
  assign buf_rd      = (state == ST_COPY) && (cnt < desc.len);
  assign byte_inc    = buf_wr || buf_rd;

  assign data_out    = buf_dout;
  assign be_data_wr  = rd_d && (cls_q == CLASS_BE);
  assign tte_data_wr = rd_d && (cls_q == CLASS_TTE);
  assign be_desc_wr  = (state == ST_DESC) && (cls_q == CLASS_BE);
  assign tte_desc_wr = (state == ST_DESC) && (cls_q == CLASS_TTE);
  assign mgnt_valid  = (state == ST_REPORT);

  // frame status, held through copy and report
  always_ff @(posedge rx_clk) begin
    if (eof) begin
      desc.giant          <= at_limit && dv;     // more data past the limit
      desc.runt           <= cnt < LEN_W'(MIN_FRAME);
      desc.crc_err        <= !crc_ok;
      desc.len            <= len_nxt;
      mgnt_report.drop    <= !room_sel;
      mgnt_report.giant   <= at_limit && dv;
      mgnt_report.runt    <= cnt < LEN_W'(MIN_FRAME);
      mgnt_report.crc_err <= !crc_ok;
      mgnt_report.rsvd    <= '0;
      mgnt_report.tte     <= (cls_q == CLASS_TTE);
      mgnt_report.len     <= room_sel ? len_nxt[11:0] : 12'd0;
    end
  end

endmodule

//--- mac_rx_top.sv
`timescale 1ns/100ps

module mac_rx_top #(
  parameter int MAX_FRAME  = 1518,
  parameter int DATA_DEPTH = 4096,
  parameter int DESC_DEPTH = 8
) (
  input  logic                       rx_clk,
  input  logic                       rstn_mac,
  input  logic                       rx_dv,
  input  logic [7:0]                 rx_d,
  input  logic                       be_data_rd,
  output logic [7:0]                 be_data_dout,
  input  logic                       be_desc_rd,
  output mac_desc_pkg::rx_desc_t     be_desc_dout,
  output logic                       be_desc_empty,
  input  logic                       tte_data_rd,
  output logic [7:0]                 tte_data_dout,
  input  logic                       tte_desc_rd,
  output mac_desc_pkg::rx_desc_t     tte_desc_dout,
  output logic                       tte_desc_empty,
  output logic                       mgnt_valid,
  output mac_desc_pkg::mgnt_report_t mgnt_report,
  input  logic                       mgnt_resp
);
  import mac_rx_pkg::*;
  import mac_desc_pkg::*;

  localparam int BUF_AW = $clog2(MAX_FRAME);

  logic             dv_r;
  logic [7:0]       d_r;
  logic [LEN_W-1:0] cnt;
  logic             at_limit;
  logic             crc_ok;
  logic             byte_inc;
  logic             byte_clr;
  logic             buf_wr;
  logic             buf_rd;
  logic [7:0]       buf_dout;
  logic [7:0]       data_out;
  logic             be_data_wr;
  logic             tte_data_wr;
  logic             be_desc_wr;
  logic             tte_desc_wr;
  logic             be_room;
  logic             tte_room;
  rx_desc_t         desc;

  // ==========================================================
  // gmii input register
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac)
      dv_r <= 1'b0;
    else
      dv_r <= rx_dv;
  end

  always_ff @(posedge rx_clk) begin
    d_r <= rx_d;
  end

  mac_rx_frame_fsm #(.MAX_FRAME(MAX_FRAME)) u_fsm (
    .rx_clk, .rstn_mac, .dv(dv_r), .din(d_r), .cnt, .at_limit, .crc_ok,
    .be_room, .tte_room, .mgnt_resp, .buf_dout, .byte_inc, .byte_clr,
    .buf_wr, .buf_rd, .be_data_wr, .tte_data_wr, .data_out,
    .be_desc_wr, .tte_desc_wr, .desc, .mgnt_valid, .mgnt_report
  );

  mac_rx_byte_cnt #(.MAX_FRAME(MAX_FRAME)) u_cnt (
    .rx_clk, .rstn_mac, .clr(byte_clr), .inc(byte_inc), .cnt, .at_limit
  );

  mac_rx_crc32 u_crc (
    .rx_clk, .rstn_mac, .init(byte_clr), .en(byte_inc), .din(d_r), .crc_ok
  );

  // same counter addresses both ports
  mac_rx_frame_buf #(.MAX_FRAME(MAX_FRAME)) u_buf (
    .rx_clk, .wr(buf_wr), .waddr(cnt[BUF_AW-1:0]), .wdata(d_r),
    .rd(buf_rd), .raddr(cnt[BUF_AW-1:0]), .rdata(buf_dout)
  );

  mac_rx_queue #(
    .DATA_DEPTH(DATA_DEPTH), .DESC_DEPTH(DESC_DEPTH), .MAX_FRAME(MAX_FRAME)
  ) u_be_queue (
    .rx_clk, .rstn_mac, .data_wr(be_data_wr), .data_in(data_out),
    .data_rd(be_data_rd), .data_dout(be_data_dout), .desc_wr(be_desc_wr),
    .desc_in(desc), .desc_rd(be_desc_rd), .desc_dout(be_desc_dout),
    .desc_empty(be_desc_empty), .room(be_room)
  );

  mac_rx_queue #(
    .DATA_DEPTH(DATA_DEPTH), .DESC_DEPTH(DESC_DEPTH), .MAX_FRAME(MAX_FRAME)
  ) u_tte_queue (
    .rx_clk, .rstn_mac, .data_wr(tte_data_wr), .data_in(data_out),
    .data_rd(tte_data_rd), .data_dout(tte_data_dout), .desc_wr(tte_desc_wr),
    .desc_in(desc), .desc_rd(tte_desc_rd), .desc_dout(tte_desc_dout),
    .desc_empty(tte_desc_empty), .room(tte_room)
  );

endmodule

//--- tb_mac_rx_assert.sv
`timescale 1ns/100ps

module tb_mac_rx_assert (
  input logic                       rx_clk,
  input logic                       rstn_mac,
  input mac_rx_pkg::rx_state_e      state,
  input logic                       mgnt_valid,
  input logic                       mgnt_resp,
  input mac_desc_pkg::mgnt_report_t mgnt_report,
  input logic                       be_desc_wr,
  input logic                       tte_desc_wr,
  input logic                       be_data_wr,
  input logic                       tte_data_wr
);
  import mac_rx_pkg::*;

  int n_fail = 0;  // failed assertions so far

  // report held until the switch answers
  a_report_stable: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    (mgnt_valid && !mgnt_resp) |=> $stable(mgnt_report))
    else begin
      $error("mgnt_report changed before mgnt_resp");
      n_fail++;
    end

  a_desc_onehot: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    !(be_desc_wr && tte_desc_wr))
    else begin
      $error("both descriptor writes active");
      n_fail++;
    end

  // write strobe lags the buffer read by one cycle
  a_data_in_copy: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    (be_data_wr || tte_data_wr) |-> ((state == ST_COPY) || ($past(state) == ST_COPY)))
    else begin
      $error("queue data write outside the copy");
      n_fail++;
    end

endmodule

//--- tb_mac_rx.sv
`timescale 1ns/100ps

module tb_mac_rx;
  import mac_rx_pkg::*;
  import mac_desc_pkg::*;

  localparam int MAX_FRAME   = 1518;
  localparam int DESC_DEPTH  = 4;
  localparam int HALF_PERIOD = 4;
  // wire bytes of all eleven frames incl. preamble and sfd
  localparam int FRAME_CYCLES    = 11 * 8 + 100 + 100 + 40 + 1530 + 7 * 64;
  localparam int WATCHDOG_CYCLES = FRAME_CYCLES * 4 + 2000;
  localparam logic [31:0] REF_POLY = 32'hEDB88320;  // reflected 802.3 polynomial

  logic         rx_clk = 1'b0;
  logic         rstn_mac;
  logic         rx_dv;
  logic [7:0]   rx_d;
  logic         be_data_rd;
  logic [7:0]   be_data_dout;
  logic         be_desc_rd;
  rx_desc_t     be_desc_dout;
  logic         be_desc_empty;
  logic         tte_data_rd;
  logic [7:0]   tte_data_dout;
  logic         tte_desc_rd;
  rx_desc_t     tte_desc_dout;
  logic         tte_desc_empty;
  logic         mgnt_valid;
  mgnt_report_t mgnt_report;
  logic         mgnt_resp;

  logic [31:0]  rng = 32'd25931;
  logic [7:0]   pay_q[$];        // frame bytes without fcs
  logic [7:0]   be_model_q[$];   // bytes expected in each queue
  logic [7:0]   tte_model_q[$];
  int           n_checks = 0;
  int           n_value_errs = 0;
  int           n_other_errs = 0;

  always #HALF_PERIOD rx_clk = ~rx_clk;

  mac_rx_top #(
    .MAX_FRAME(MAX_FRAME), .DATA_DEPTH(4096), .DESC_DEPTH(DESC_DEPTH)
  ) UUT (
    .rx_clk, .rstn_mac, .rx_dv, .rx_d,
    .be_data_rd, .be_data_dout, .be_desc_rd, .be_desc_dout, .be_desc_empty,
    .tte_data_rd, .tte_data_dout, .tte_desc_rd, .tte_desc_dout, .tte_desc_empty,
    .mgnt_valid, .mgnt_report, .mgnt_resp
  );

  bind mac_rx_frame_fsm tb_mac_rx_assert u_fsm_assert (
    .rx_clk, .rstn_mac, .state, .mgnt_valid, .mgnt_resp, .mgnt_report,
    .be_desc_wr, .tte_desc_wr, .be_data_wr, .tte_data_wr
  );

  // ==========================================================
  // reference models
  // ==========================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] fcs_crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ REF_POLY) : (c >> 1);
    end
    return c;
  endfunction

  function automatic rx_desc_t make_desc(input logic giant, input logic runt,
                                         input logic crc_err, input int len);
    rx_desc_t d;
    d.giant   = giant;
    d.runt    = runt;
    d.crc_err = crc_err;
    d.len     = LEN_W'(len);
    return d;
  endfunction

  function automatic mgnt_report_t make_report(input logic drop, input logic giant,
                                               input logic runt, input logic crc_err,
                                               input logic tte, input int len);
    mgnt_report_t r;
    r.drop    = drop;
    r.giant   = giant;
    r.runt    = runt;
    r.crc_err = crc_err;
    r.rsvd    = 3'b000;
    r.tte     = tte;
    r.len     = drop ? 12'd0 : 12'(len);  // dropped frames report no length
    return r;
  endfunction

  // ==========================================================
  // compare tasks
  // ==========================================================
  task automatic check_desc(input string name, input rx_desc_t got, input rx_desc_t want);
    n_checks++;
    if (got !== want) begin
      n_value_errs++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_report(input string name, input mgnt_report_t got,
                              input mgnt_report_t want);
    n_checks++;
    if (got !== want) begin
      n_value_errs++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
    n_checks++;
    if (got !== want) begin
      n_value_errs++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    n_checks++;
    if (got !== want) begin
      n_value_errs++;
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic note_failure(input string what);
    n_other_errs++;
    $display("%0t: %s", $time, what);
  endtask

  // ==========================================================
  // gmii driver and queue readers
  // ==========================================================
  task automatic build_frame(input int total_len, input bit tte);
    pay_q.delete();
    for (int i = 0; i < total_len - FCS_BYTES; i++) begin
      rng = xorshift32(rng);
      pay_q.push_back(rng[7:0]);
    end
    pay_q[12] = tte ? 8'h88 : 8'h08;                      // ethertype high byte
    pay_q[TYPE_BYTE_INDEX] = tte ? 8'h92 : 8'h00;
  endtask

  task automatic drive_byte(input logic [7:0] b);
    @(posedge rx_clk);
    rx_dv <= 1'b1;
    rx_d  <= b;
  endtask

  task automatic send_frame(input bit bad_fcs);
    logic [31:0] crc;
    logic [31:0] fcs;
    crc = '1;
    foreach (pay_q[i])
      crc = fcs_crc_byte(crc, pay_q[i]);
    fcs = ~crc;
    if (bad_fcs)
      fcs[0] = ~fcs[0];
    repeat (7) drive_byte(8'h55);
    drive_byte(8'hD5);
    foreach (pay_q[i])
      drive_byte(pay_q[i]);
    for (int k = 0; k < 4; k++)
      drive_byte(fcs[8*k +: 8]);    // lsb first
    @(posedge rx_clk);
    rx_dv <= 1'b0;
    rx_d  <= 8'h00;
    repeat (12) @(posedge rx_clk);  // interframe gap
  endtask

  task automatic stash_frame(input bit tte, input int n);
    for (int i = 0; i < n; i++) begin
      if (tte)
        tte_model_q.push_back(pay_q[i]);
      else
        be_model_q.push_back(pay_q[i]);
    end
  endtask

  task automatic take_report(output mgnt_report_t rep);
    @(negedge rx_clk);
    while (!mgnt_valid)
      @(negedge rx_clk);
    rep = mgnt_report;
    @(posedge rx_clk);
    mgnt_resp <= 1'b1;
    @(posedge rx_clk);
    mgnt_resp <= 1'b0;
  endtask

  task automatic pop_desc(input bit tte, output rx_desc_t d);
    @(negedge rx_clk);
    if (tte ? tte_desc_empty : be_desc_empty)
      note_failure("descriptor FIFO is empty where a frame should be queued");
    @(posedge rx_clk);
    if (tte)
      tte_desc_rd <= 1'b1;
    else
      be_desc_rd <= 1'b1;
    @(posedge rx_clk);
    tte_desc_rd <= 1'b0;
    be_desc_rd  <= 1'b0;
    @(negedge rx_clk);
    d = tte ? tte_desc_dout : be_desc_dout;
  endtask

  task automatic pop_data(input bit tte, input int n);
    logic [7:0] want;
    @(posedge rx_clk);
    if (tte)
      tte_data_rd <= 1'b1;
    else
      be_data_rd <= 1'b1;
    for (int i = 0; i < n; i++) begin
      @(posedge rx_clk);
      if (i == n - 1) begin
        tte_data_rd <= 1'b0;
        be_data_rd  <= 1'b0;
      end
      @(negedge rx_clk);
      if ((tte ? tte_model_q.size() : be_model_q.size()) == 0) begin
        note_failure("more bytes read than frames were queued");
      end else begin
        want = tte ? tte_model_q.pop_front() : be_model_q.pop_front();
        check_byte(tte ? "tte_data_dout" : "be_data_dout",
                   tte ? tte_data_dout : be_data_dout, want);
      end
    end
  endtask

  // full path of one accepted frame: report, descriptor, bytes
  task automatic accept_frame(input int total_len, input bit tte, input bit bad_fcs,
                              input logic giant, input logic runt, input logic crc_err);
    mgnt_report_t rep;
    rx_desc_t     d;
    int           stored;
    stored = ((total_len > MAX_FRAME) ? MAX_FRAME : total_len) - FCS_BYTES;
    build_frame(total_len, tte);
    send_frame(bad_fcs);
    take_report(rep);
    check_report("mgnt_report", rep, make_report(1'b0, giant, runt, crc_err, tte, stored));
    stash_frame(tte, stored);
    pop_desc(tte, d);
    check_desc(tte ? "tte_desc_dout" : "be_desc_dout", d,
               make_desc(giant, runt, crc_err, stored));
    pop_data(tte, stored);
  endtask

  // ==========================================================
  // directed tests
  // ==========================================================
  task automatic reset_values();
    @(negedge rx_clk);
    check_flag("mgnt_valid", mgnt_valid, 1'b0);
    check_flag("be_desc_empty", be_desc_empty, 1'b1);
    check_flag("tte_desc_empty", tte_desc_empty, 1'b1);
  endtask

  task automatic be_frame_path();
    accept_frame(100, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic tte_classification();
    accept_frame(64, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    check_flag("be_desc_empty", be_desc_empty, 1'b1);   // nothing leaked to be
  endtask

  task automatic frame_flags();
    accept_frame(100, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    accept_frame(40, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    // truncated frame never reaches its fcs, so the crc fails too
    accept_frame(1530, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic queue_backpressure();
    mgnt_report_t rep;
    rx_desc_t     d;
    for (int k = 0; k < DESC_DEPTH; k++) begin
      build_frame(64, 1'b0);
      send_frame(1'b0);
      take_report(rep);
      check_report("mgnt_report", rep, make_report(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 60));
      stash_frame(1'b0, 60);
    end
    build_frame(64, 1'b0);          // descriptor fifo full, so dropped
    send_frame(1'b0);
    take_report(rep);
    check_report("mgnt_report", rep, make_report(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0));
    accept_frame(64, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int k = 0; k < DESC_DEPTH; k++) begin
      pop_desc(1'b0, d);
      check_desc("be_desc_dout", d, make_desc(1'b0, 1'b0, 1'b0, 60));
      pop_data(1'b0, 60);
    end
    @(negedge rx_clk);
    check_flag("be_desc_empty", be_desc_empty, 1'b1);
  endtask

  initial begin
    rstn_mac    = 1'b0;
    rx_dv       = 1'b0;
    rx_d        = 8'h00;
    be_data_rd  = 1'b0;
    be_desc_rd  = 1'b0;
    tte_data_rd = 1'b0;
    tte_desc_rd = 1'b0;
    mgnt_resp   = 1'b0;
    repeat (8) @(posedge rx_clk);
    rstn_mac <= 1'b1;
    reset_values();
    be_frame_path();
    tte_classification();
    frame_flags();
    queue_backpressure();
    repeat (10) @(posedge rx_clk);
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             n_checks, n_value_errs, n_other_errs, UUT.u_fsm.u_fsm_assert.n_fail);
    if (n_value_errs + n_other_errs + UUT.u_fsm.u_fsm_assert.n_fail == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // run limit scaled to the traffic
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge rx_clk);
    n_other_errs++;
    $display("%0t: watchdog expired, the DUT stopped answering", $time);
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             n_checks, n_value_errs, n_other_errs, UUT.u_fsm.u_fsm_assert.n_fail);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- project.f
mac_rx_pkg.sv
mac_desc_pkg.sv
mac_rx_byte_cnt.sv
mac_rx_crc32.sv
mac_rx_frame_buf.sv
mac_rx_queue.sv
mac_rx_frame_fsm.sv
mac_rx_top.sv
tb_mac_rx_assert.sv
tb_mac_rx.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mac_rx
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Done: errors found
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
